// ==== hdl/pmu_macros.svh ====
`ifndef PMU_MACROS_SVH
`define PMU_MACROS_SVH

// session header length, sent lsb first
`define PMU_HDR_BITS 64

// crc key bits at the head of each frame
`define PMU_KEY_BITS 8

// fabric data bits per frame
`define PMU_FRAME_BITS 64

// x^8+x^7+x^6+x^5+x^3+x+1, x^8 implicit
`define PMU_CRC_POLY 8'hEB

// passed-frame counter width
`define PMU_CNT_BITS 16

`endif

// ==== hdl/pmu_pkg.sv ====
`default_nettype none
`include "pmu_macros.svh"

package pmu_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HEADER,
        ST_KEY,
        ST_DATA,
        ST_DONE
    } pmu_state_e;

    // one extra bit so the header length itself fits
    typedef logic [$clog2(`PMU_HDR_BITS):0] pmu_bitcnt_t;

endpackage

`default_nettype wire

// ==== hdl/pmu_stream_if.sv ====
`default_nettype none

interface pmu_stream_if;

    logic bit_valid;     // key or data bit this cycle
    logic bit_data;
    logic frame_start;   // first key bit
    logic frame_end;     // last data bit
    logic last_frame;
    logic check_en;
    logic session_start; // header bit 0

    modport src (
        output bit_valid,
        output bit_data,
        output frame_start,
        output frame_end,
        output last_frame,
        output check_en,
        output session_start
    );

    modport snk (
        input bit_valid,
        input bit_data,
        input frame_start,
        input frame_end,
        input last_frame,
        input check_en,
        input session_start
    );

endinterface

`default_nettype wire

// ==== hdl/pmu_sequencer.sv ====
`default_nettype none
`include "pmu_macros.svh"

module pmu_sequencer (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic en_i,
    input  wire logic data_i,
    input  wire logic checksum_en_i,
    output logic      prog_en_o,
    output logic      prog_data_o,
    pmu_stream_if.src strm
);

    pmu_pkg::pmu_state_e state_q;
    pmu_pkg::pmu_state_e state_d;

    logic [`PMU_HDR_BITS-1:0] hdr_q;
    logic [`PMU_HDR_BITS-1:0] hdr_next;
    logic [31:0]              frames_left_q;
    pmu_pkg::pmu_bitcnt_t     bit_cnt_q;
    logic                     check_en_q;

    logic hdr_last;
    logic key_last;
    logic data_last;
    logic in_frame;
    logic last_frame;
    logic tail_ok;
    logic fwd_bit;

    assign hdr_next  = {data_i, hdr_q[`PMU_HDR_BITS-1:1]}; // lsb arrives first

    assign hdr_last  = (bit_cnt_q == pmu_pkg::pmu_bitcnt_t'(`PMU_HDR_BITS - 1));
    assign key_last  = (bit_cnt_q == pmu_pkg::pmu_bitcnt_t'(`PMU_KEY_BITS - 1));
    assign data_last = (bit_cnt_q == pmu_pkg::pmu_bitcnt_t'(`PMU_FRAME_BITS - 1));

    assign in_frame   = (state_q == pmu_pkg::ST_KEY) || (state_q == pmu_pkg::ST_DATA);
    assign last_frame = in_frame && (frames_left_q == 32'd1);

    // L compare, only the first L bits of frame N reach the fabric
    assign tail_ok = (32'(bit_cnt_q) < hdr_q[`PMU_HDR_BITS-1:32]);
    assign fwd_bit = en_i && (state_q == pmu_pkg::ST_DATA) && (!last_frame || tail_ok);

    always_comb
    begin
        state_d = state_q;
        unique case (state_q)
            pmu_pkg::ST_IDLE:
            begin
                if (en_i)
                    state_d = pmu_pkg::ST_HEADER; // this edge takes header bit 0
            end
            pmu_pkg::ST_HEADER:
            begin
                if (!en_i)
                    state_d = pmu_pkg::ST_IDLE;
                else if (hdr_last)
                    state_d = pmu_pkg::ST_KEY;
            end
            pmu_pkg::ST_KEY:
            begin
                if (!en_i)
                    state_d = pmu_pkg::ST_IDLE;
                else if (key_last)
                    state_d = pmu_pkg::ST_DATA;
            end
            pmu_pkg::ST_DATA:
            begin
                if (!en_i)
                    state_d = pmu_pkg::ST_IDLE;
                else if (data_last)
                    state_d = last_frame ? pmu_pkg::ST_DONE : pmu_pkg::ST_KEY;
            end
            pmu_pkg::ST_DONE:
            begin
                if (!en_i)
                    state_d = pmu_pkg::ST_IDLE; // wait for the session to close
            end
            default:
            begin
                state_d = pmu_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            state_q       <= pmu_pkg::ST_IDLE;
            bit_cnt_q     <= '0;
            frames_left_q <= '0;
            check_en_q    <= 1'b0;
            prog_en_o     <= 1'b0;
            prog_data_o   <= 1'b0;
        end
        else
        begin
            state_q     <= state_d;
            check_en_q  <= checksum_en_i;
            prog_en_o   <= fwd_bit;
            prog_data_o <= fwd_bit & data_i;

            if (state_q == pmu_pkg::ST_IDLE)
                bit_cnt_q <= pmu_pkg::pmu_bitcnt_t'(1);
            else if ((state_d != state_q) || (state_q == pmu_pkg::ST_DONE))
                bit_cnt_q <= '0;
            else
                bit_cnt_q <= bit_cnt_q + 1'b1;

            if (en_i && (state_q == pmu_pkg::ST_HEADER) && hdr_last)
                frames_left_q <= hdr_next[31:0];
            else if (en_i && (state_q == pmu_pkg::ST_DATA) && data_last)
                frames_left_q <= frames_left_q - 32'd1;
        end
    end

    // header shifts in from idle so bit 0 is not lost
    always_ff @(posedge clk_i)
    begin
        if (en_i && ((state_q == pmu_pkg::ST_IDLE) || (state_q == pmu_pkg::ST_HEADER)))
            hdr_q <= hdr_next;
    end

    assign strm.bit_valid     = en_i && in_frame;
    assign strm.bit_data      = data_i;
    assign strm.frame_start   = en_i && (state_q == pmu_pkg::ST_KEY) && (bit_cnt_q == '0);
    assign strm.frame_end     = en_i && (state_q == pmu_pkg::ST_DATA) && data_last;
    assign strm.last_frame    = last_frame;
    assign strm.check_en      = check_en_q;
    assign strm.session_start = en_i && (state_q == pmu_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== hdl/pmu_crc_check.sv ====
`default_nettype none
`include "pmu_macros.svh"

module pmu_crc_check (
    input  wire logic clk_i,
    input  wire logic rst_i,
    pmu_stream_if.snk strm,
    output logic      frame_pass_o,
    output logic      frame_fail_o,
    output logic      frame_last_o
);

    logic [`PMU_KEY_BITS-1:0] crc_q;
    logic [`PMU_KEY_BITS-1:0] crc_seed;
    logic [`PMU_KEY_BITS-1:0] crc_next;
    logic                     check_q;
    logic                     crc_ok;

    // msb feedback, new bit enters at the lsb
    function automatic logic [`PMU_KEY_BITS-1:0] crc_step(
        input logic [`PMU_KEY_BITS-1:0] crc,
        input logic                     din
    );
        logic [`PMU_KEY_BITS-1:0] poly;
        poly     = crc[`PMU_KEY_BITS-1] ? `PMU_CRC_POLY : '0;
        crc_step = {crc[`PMU_KEY_BITS-2:0], din} ^ poly;
    endfunction

    assign crc_seed = strm.frame_start ? '0 : crc_q; // fresh remainder per frame
    assign crc_next = crc_step(crc_seed, strm.bit_data);
    assign crc_ok   = !check_q || (crc_next == '0);

    always_ff @(posedge clk_i)
    begin
        if (strm.bit_valid)
            crc_q <= crc_next;
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            check_q      <= 1'b0;
            frame_pass_o <= 1'b0;
            frame_fail_o <= 1'b0;
            frame_last_o <= 1'b0;
        end
        else
        begin
            if (strm.frame_start)
                check_q <= strm.check_en; // held for the whole frame
            frame_pass_o <= strm.frame_end && crc_ok;
            frame_fail_o <= strm.frame_end && !crc_ok;
            frame_last_o <= strm.frame_end && strm.last_frame;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pmu_status.sv ====
`default_nettype none
`include "pmu_macros.svh"

module pmu_status (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    pmu_stream_if.snk                     strm,
    input  wire logic                     frame_pass_i,
    input  wire logic                     frame_fail_i,
    input  wire logic                     frame_last_i,
    output logic                          frame_done_o,
    output logic                          done_o,
    output logic                          crc_err_o,
    output logic [`PMU_CNT_BITS-1:0]      frames_ok_o
);

    logic frame_cmp;
    logic cnt_full;

    assign frame_cmp = frame_pass_i | frame_fail_i;
    assign cnt_full  = &frames_ok_o;

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            frame_done_o <= 1'b0;
            done_o       <= 1'b0;
        end
        else
        begin
            frame_done_o <= frame_cmp;
            done_o       <= frame_cmp && frame_last_i; // with the last frame_done
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            crc_err_o   <= 1'b0;
            frames_ok_o <= '0;
        end
        else if (strm.session_start)
        begin
            // new session starts clean
            crc_err_o   <= 1'b0;
            frames_ok_o <= '0;
        end
        else
        begin
            if (frame_fail_i)
                crc_err_o <= 1'b1;
            if (frame_pass_i && !cnt_full)
                frames_ok_o <= frames_ok_o + 1'b1; // saturates
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pmu_top.sv ====
`default_nettype none
`include "pmu_macros.svh"

module pmu_top (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                en_i,
    input  wire logic                data_i,
    input  wire logic                checksum_en_i,
    output logic                     prog_en_o,
    output logic                     prog_data_o,
    output logic                     frame_done_o,
    output logic                     done_o,
    output logic                     crc_err_o,
    output logic [`PMU_CNT_BITS-1:0] frames_ok_o
);

    logic frame_pass;
    logic frame_fail;
    logic frame_last;

    pmu_stream_if strm ();

    // decode
    pmu_sequencer u_sequencer (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .data_i        (data_i),
        .checksum_en_i (checksum_en_i),
        .prog_en_o     (prog_en_o),
        .prog_data_o   (prog_data_o),
        .strm          (strm.src)
    );

    // execute
    pmu_crc_check u_crc_check (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .strm         (strm.snk),
        .frame_pass_o (frame_pass),
        .frame_fail_o (frame_fail),
        .frame_last_o (frame_last)
    );

    // result
    pmu_status u_status (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .strm         (strm.snk),
        .frame_pass_i (frame_pass),
        .frame_fail_i (frame_fail),
        .frame_last_i (frame_last),
        .frame_done_o (frame_done_o),
        .done_o       (done_o),
        .crc_err_o    (crc_err_o),
        .frames_ok_o  (frames_ok_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_pmu.sv ====
`default_nettype none
`include "pmu_macros.svh"

module tb_pmu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HDR_W   = `PMU_HDR_BITS;
    localparam int KEY_W   = `PMU_KEY_BITS;
    localparam int FRAME_W = `PMU_FRAME_BITS;

    logic                     clk_i;
    logic                     rst_i;
    logic                     en_i;
    logic                     data_i;
    logic                     checksum_en_i;
    logic                     prog_en_o;
    logic                     prog_data_o;
    logic                     frame_done_o;
    logic                     done_o;
    logic                     crc_err_o;
    logic [`PMU_CNT_BITS-1:0] frames_ok_o;

    logic [31:0] lcg_state;
    logic        exp_q[$]; // fabric bits the dut should forward
    logic        fwd_q[$]; // fabric bits seen on prog_data_o
    int          frame_done_cnt;
    int          done_cnt;

    pmu_top uut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (en_i),
        .data_i        (data_i),
        .checksum_en_i (checksum_en_i),
        .prog_en_o     (prog_en_o),
        .prog_data_o   (prog_data_o),
        .frame_done_o  (frame_done_o),
        .done_o        (done_o),
        .crc_err_o     (crc_err_o),
        .frames_ok_o   (frames_ok_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else
            fail_run($sformatf("ERR %s got 0x%0h exp 0x%0h", name, got, exp));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // msb feedback, new bit at the lsb
    function automatic logic [KEY_W-1:0] ref_crc_bit(input logic [KEY_W-1:0] crc, input logic b);
        logic [KEY_W-1:0] nxt;
        nxt = {crc[KEY_W-2:0], b};
        if (crc[KEY_W-1])
            nxt = nxt ^ `PMU_CRC_POLY;
        return nxt;
    endfunction

    // key goes first, msb first, then data lsb first
    function automatic logic [KEY_W-1:0] ref_crc_frame(input logic [KEY_W-1:0] key,
                                                      input logic [FRAME_W-1:0] data);
        logic [KEY_W-1:0] crc;
        int               i;
        crc = '0;
        for (i = KEY_W - 1; i >= 0; i--)
            crc = ref_crc_bit(crc, key[i]);
        for (i = 0; i < FRAME_W; i++)
            crc = ref_crc_bit(crc, data[i]);
        return crc;
    endfunction

    task automatic find_key(input logic [FRAME_W-1:0] data, output logic [KEY_W-1:0] key);
        int   k;
        logic found;
        found = 1'b0;
        key   = '0;
        for (k = 0; k < (1 << KEY_W); k++)
        begin
            if (!found && (ref_crc_frame(KEY_W'(k), data) == '0))
            begin
                key   = KEY_W'(k);
                found = 1'b1;
            end
        end
        if (!found)
            fail_run("no key gives a zero remainder for this frame");
    endtask

    task automatic idle_cycles(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // present one bit, consumed at the next rising edge
    task automatic send_bit(input logic b);
        en_i   = 1'b1;
        data_i = b;
        @(posedge clk_i);
        #1;
    endtask

    task automatic run_session(input int n, input int l, input int bad_frame,
                               input logic chk, input int abort_at);
        logic [HDR_W-1:0]   hdr;
        logic [FRAME_W-1:0] data;
        logic [KEY_W-1:0]   key;
        int                 f;
        int                 i;
        int                 flip;
        int                 sent;
        exp_q.delete();
        fwd_q.delete();
        frame_done_cnt = 0;
        done_cnt       = 0;
        sent           = 0;
        checksum_en_i  = chk;
        hdr            = {32'(l), 32'(n)};
        for (i = 0; i < HDR_W; i++)
        begin
            send_bit(hdr[i]);
            if (i == 0)
            begin
                // session start wipes the old results
                check_val("crc_err_o", crc_err_o, 0);
                check_val("frames_ok_o", frames_ok_o, 0);
            end
        end
        for (f = 1; f <= n; f++)
        begin
            data = {lcg_next(), lcg_next()};
            find_key(data, key);
            if (f == bad_frame)
            begin
                flip       = int'(lcg_next() >> 16) % FRAME_W;
                data[flip] = ~data[flip]; // key no longer matches
            end
            for (i = KEY_W - 1; i >= 0; i--)
                send_bit(key[i]);
            for (i = 0; i < FRAME_W; i++)
            begin
                if (sent == abort_at)
                begin
                    en_i   = 1'b0;
                    data_i = 1'b0;
                    return;
                end
                if ((f < n) || (i < l))
                    exp_q.push_back(data[i]);
                send_bit(data[i]);
                sent++;
            end
        end
        en_i   = 1'b0;
        data_i = 1'b0;
    endtask

    task automatic compare_fwd();
        int i;
        check_val("prog_en_o bit count", fwd_q.size(), exp_q.size());
        for (i = 0; i < exp_q.size(); i++)
            check_val($sformatf("prog_data_o[%0d]", i), fwd_q[i], exp_q[i]);
    endtask

    task automatic finish_session(input int n, input int l, input int exp_ok,
                                  input logic exp_err);
        int waited;
        for (waited = 1; waited <= 20; waited++)
        begin
            @(negedge clk_i);
            if (done_o)
                break;
        end
        if (!done_o)
            fail_run("timeout waiting for done_o after the last frame");
        check_val("done_o latency", waited, 2); // second cycle after the last bit
        idle_cycles(4);
        check_val("done_o pulses", done_cnt, 1);
        check_val("frame_done_o pulses", frame_done_cnt, n);
        check_val("frames_ok_o", frames_ok_o, exp_ok);
        check_val("crc_err_o", crc_err_o, exp_err);
        check_val("prog_en_o bits", fwd_q.size(), (n - 1) * FRAME_W + l);
        compare_fwd();
    endtask

    task automatic check_abort(input int frames_done, input int exp_ok);
        int waited;
        for (waited = 1; waited <= 10; waited++)
        begin
            @(negedge clk_i);
            if (!prog_en_o)
                break;
        end
        if (prog_en_o)
            fail_run("timeout waiting for prog_en_o to drop after the abort");
        idle_cycles(8);
        check_val("prog_en_o", prog_en_o, 0);
        check_val("done_o pulses", done_cnt, 0);
        check_val("frame_done_o pulses", frame_done_cnt, frames_done);
        check_val("crc_err_o", crc_err_o, 1);
        check_val("frames_ok_o", frames_ok_o, exp_ok);
        compare_fwd();
    endtask

    // monitor, samples away from the active edge
    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            if (prog_en_o)
                fwd_q.push_back(prog_data_o);
            if (frame_done_o)
                frame_done_cnt++;
            if (done_o)
                done_cnt++;
            assert (!done_o || frame_done_o)
            else
                fail_run("done_o pulsed without frame_done_o");
            assert (prog_en_o || !prog_data_o)
            else
                fail_run("prog_data_o high while prog_en_o is low");
        end
    end

    initial
    begin
        lcg_state      = 32'd20933;
        rst_i          = 1'b0;
        en_i           = 1'b0;
        data_i         = 1'b0;
        checksum_en_i  = 1'b0;
        frame_done_cnt = 0;
        done_cnt       = 0;
        idle_cycles(3);
        rst_i = 1'b1;

        // quiet outputs before the first session
        idle_cycles(2);
        check_val("prog_en_o", prog_en_o, 0);
        check_val("prog_data_o", prog_data_o, 0);
        check_val("frame_done_o", frame_done_o, 0);
        check_val("done_o", done_o, 0);
        check_val("crc_err_o", crc_err_o, 0);
        check_val("frames_ok_o", frames_ok_o, 0);

        run_session(3, 20, 0, 1'b1, -1);
        finish_session(3, 20, 3, 1'b0);

        // frame 2 corrupted
        run_session(3, 20, 2, 1'b1, -1);
        finish_session(3, 20, 2, 1'b1);

        // same corruption with checking off
        run_session(3, 20, 2, 1'b0, -1);
        finish_session(3, 20, 3, 1'b0);

        // abort in frame 3, then a clean session
        run_session(4, 20, 2, 1'b1, 2 * FRAME_W + 30);
        check_abort(2, 1);
        run_session(3, 20, 0, 1'b1, -1);
        finish_session(3, 20, 3, 1'b0);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/pmu_pkg.sv
hdl/pmu_stream_if.sv
hdl/pmu_sequencer.sv
hdl/pmu_crc_check.sv
hdl/pmu_status.sv
hdl/pmu_top.sv
tb/tb_pmu.sv

// ==== Bender.yml ====
package:
  name: pmu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pmu_pkg.sv
      - hdl/pmu_stream_if.sv
      - hdl/pmu_sequencer.sv
      - hdl/pmu_crc_check.sv
      - hdl/pmu_status.sv
      - hdl/pmu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_pmu.sv
